// ==== logic/rom_load_pkg.sv ====
/*
 * ROM loader shared types
 * Widths, request structs and PROM count used across the loader
 */
`default_nettype none

package rom_load_pkg;

    localparam int PROM_COUNT = 14; // Lookup PROMs on the board

    typedef logic [21:0] ioctl_addr_t; // Host byte address
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] rom_word_t;   // Shared memory word
    typedef logic [1:0]  byte_mask_t;  // Active low, bit 0 is low byte
    typedef logic [3:0]  prom_sel_t;   // PROM index 0..13
    typedef logic [PROM_COUNT-1:0] prom_we_t; // One strobe per PROM

    // Program ROM write from the decoder
    typedef struct packed {
        ioctl_addr_t addr; // Word address
        byte_t       data; // Goes on both lanes
        byte_mask_t  mask;
        logic        we;
    } prog_req_t;

    // PROM write, one-hot strobe
    typedef struct packed {
        prom_we_t we;
        byte_t    addr; // Entry within the PROM
        byte_t    data;
    } prom_wr_t;

endpackage

`default_nettype wire

// ==== logic/download_decoder.sv ====
/*
 * Download decoder
 * Sorts host bytes into program ROM writes or one-hot PROM strobes
 */
`default_nettype none

module download_decoder import rom_load_pkg::*; #(
    parameter int unsigned PROM_BASE = 32768
) (
    input  wire logic        clk_rgb,
    input  wire logic        arst_n,
    input  wire logic        downloading,
    input  wire ioctl_addr_t ioctl_addr,
    input  wire byte_t       ioctl_data,
    input  wire logic        ioctl_wr,
    output prog_req_t        prog_req,
    output prom_wr_t         prom_wr
);

    logic        accept;   // Byte taken this cycle
    logic        is_prog;  // Below the PROM boundary
    logic        prom_hit; // Falls in a PROM region
    prom_sel_t   prom_idx;

    logic        prog_we_q;
    ioctl_addr_t prog_addr_q;
    byte_mask_t  prog_mask_q;
    byte_t       data_q;   // Shared by both outputs
    prom_we_t    prom_we_q;
    byte_t       prom_addr_q;

    assign accept  = downloading && ioctl_wr; // Drop bytes outside a download
    assign is_prog = ioctl_addr < ioctl_addr_t'(PROM_BASE);

    // PROM region decode
    always_comb begin
        prom_hit = 1'b0;
        prom_idx = '0;
        if (!is_prog) begin
            if (!ioctl_addr[16]) begin
                prom_hit = 1'b1;
                prom_idx = 4'd6 + {1'b0, ioctl_addr[15:13]}; // PROMs 6..13
            end else if (ioctl_addr[12:11] == 2'b01) begin
                prom_hit = 1'b1;
                prom_idx = 4'd5; // Character table
            end else if (ioctl_addr[12]) begin
                prom_hit = 1'b1;
                case (ioctl_addr[9:8])
                    2'd0: prom_idx = 4'd0; // Timing
                    2'd1: prom_idx = 4'd1; // Object palette
                    2'd2: prom_idx = 4'd2; // Object palette
                    default: prom_idx = ioctl_addr[5] ? 4'd4 : 4'd3;
                endcase
            end
            // Anything else falls through and is discarded
        end
    end

    // Strobes, cleared on reset
    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            prog_we_q <= 1'b0;
            prom_we_q <= '0;
        end else begin
            prog_we_q <= accept && is_prog;  // One-cycle pulse
            prom_we_q <= (accept && prom_hit) ? prom_we_t'(1) << prom_idx : '0;
        end
    end

    // Payload follows each accepted byte
    always_ff @(posedge clk_rgb) begin
        if (accept) begin
            prog_addr_q <= ioctl_addr >> 1;                  // Byte to word
            prog_mask_q <= {~ioctl_addr[0], ioctl_addr[0]};  // Even enables low lane
            data_q      <= ioctl_data;
            prom_addr_q <= ioctl_addr[7:0];                  // PROM entry
        end
    end

    assign prog_req = '{addr: prog_addr_q, data: data_q, mask: prog_mask_q, we: prog_we_q};
    assign prom_wr  = '{we: prom_we_q, addr: prom_addr_q, data: data_q};

endmodule

`default_nettype wire

// ==== logic/rom_arbiter.sv ====
/*
 * Shared ROM arbiter
 * Loader writes always win; one CPU read is held until a free cycle
 */
`default_nettype none

module rom_arbiter import rom_load_pkg::*; #(
    parameter int ROM_AW = 14
) (
    input  wire logic              clk_rgb,
    input  wire logic              arst_n,
    input  wire prog_req_t         prog_req,
    input  wire logic              cpu_rd,
    input  wire logic [ROM_AW-1:0] cpu_addr,
    output rom_word_t              cpu_data,
    output logic                   cpu_valid,
    output logic                   mem_we,
    output logic [ROM_AW-1:0]      mem_addr,
    output rom_word_t              mem_wdata,
    output byte_mask_t             mem_mask,
    input  wire rom_word_t         mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PENDING, // Read parked behind a write
        ST_RETURN   // Read data arriving from memory
    } arb_state_t;

    arb_state_t        state;
    arb_state_t        state_nxt;
    logic [ROM_AW-1:0] pend_addr; // Parked read address

    // Memory port mux
    assign mem_we    = prog_req.we;
    assign mem_wdata = {prog_req.data, prog_req.data}; // Byte on both lanes
    assign mem_mask  = prog_req.we ? prog_req.mask : 2'b11;

    always_comb begin
        if (prog_req.we)
            mem_addr = prog_req.addr[ROM_AW-1:0];
        else if (state == ST_PENDING)
            mem_addr = pend_addr;
        else
            mem_addr = cpu_addr; // Read presented at once
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:    if (cpu_rd) state_nxt = prog_req.we ? ST_PENDING : ST_RETURN;
            ST_PENDING: if (!prog_req.we) state_nxt = ST_RETURN;
            ST_RETURN:  state_nxt = ST_IDLE;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_rgb or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            cpu_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            cpu_valid <= state == ST_RETURN; // Two cycles after an unblocked read
        end
    end

    always_ff @(posedge clk_rgb) begin
        if (state == ST_IDLE && cpu_rd)
            pend_addr <= cpu_addr;
        if (state == ST_RETURN)
            cpu_data <= mem_rdata;
    end

endmodule

`default_nettype wire

// ==== logic/rom_memory.sv ====
/*
 * Shared ROM memory
 * 16-bit synchronous RAM with active-low lane mask and registered read
 */
`default_nettype none

module rom_memory import rom_load_pkg::*; #(
    parameter int ROM_AW = 14
) (
    input  wire logic              clk_rgb,
    input  wire logic              we,
    input  wire logic [ROM_AW-1:0] addr,
    input  wire rom_word_t         wdata,
    input  wire byte_mask_t        mask,
    output rom_word_t              rdata
);

    rom_word_t mem [2**ROM_AW]; // Program ROM storage

    always_ff @(posedge clk_rgb) begin
        if (we) begin
            if (!mask[0])
                mem[addr][7:0] <= wdata[7:0];   // Low lane
            if (!mask[1])
                mem[addr][15:8] <= wdata[15:8]; // High lane
        end
        rdata <= mem[addr]; // One cycle latency
    end

endmodule

`default_nettype wire

// ==== logic/prom_bank.sv ====
/*
 * Lookup PROM bank
 * Fourteen 256-byte tables, strobe written, one selected for read
 */
`default_nettype none

module prom_bank import rom_load_pkg::*; (
    input  wire logic      clk_rgb,
    input  wire prom_wr_t  prom_wr,
    input  wire prom_sel_t rd_sel,
    input  wire byte_t     rd_addr,
    output byte_t          rd_data
);

    byte_t prom [PROM_COUNT][256];

    // Write whichever PROM is strobed
    always_ff @(posedge clk_rgb) begin
        for (int i = 0; i < PROM_COUNT; i++) begin
            if (prom_wr.we[i])
                prom[i][prom_wr.addr] <= prom_wr.data;
        end
    end

    // Registered read, zero for unused selectors
    always_ff @(posedge clk_rgb) begin
        if (rd_sel < prom_sel_t'(PROM_COUNT))
            rd_data <= prom[rd_sel][rd_addr];
        else
            rd_data <= '0;
    end

endmodule

`default_nettype wire

// ==== logic/rom_load_top.sv ====
/*
 * ROM loader top
 * Download decoder, shared memory with arbiter, and lookup PROMs
 */
`default_nettype none

module rom_load_top import rom_load_pkg::*; #(
    parameter int unsigned PROM_BASE = 32768,
    parameter int          ROM_AW    = 14
) (
    input  wire logic              clk_rgb,
    input  wire logic              arst_n,
    input  wire logic              downloading,
    input  wire ioctl_addr_t       ioctl_addr,
    input  wire byte_t             ioctl_data,
    input  wire logic              ioctl_wr,
    input  wire logic              cpu_rd,
    input  wire logic [ROM_AW-1:0] cpu_addr,
    output rom_word_t              cpu_data,
    output logic                   cpu_valid,
    input  wire prom_sel_t         prom_rd_sel,
    input  wire byte_t             prom_rd_addr,
    output byte_t                  prom_rd_data
);

    prog_req_t         prog_req;
    prom_wr_t          prom_wr;
    logic              mem_we;
    logic [ROM_AW-1:0] mem_addr;
    rom_word_t         mem_wdata;
    byte_mask_t        mem_mask;
    rom_word_t         mem_rdata;

    download_decoder #(.PROM_BASE(PROM_BASE)) download_decoder_i (
        .clk_rgb    (clk_rgb),
        .arst_n     (arst_n),
        .downloading(downloading),
        .ioctl_addr (ioctl_addr),
        .ioctl_data (ioctl_data),
        .ioctl_wr   (ioctl_wr),
        .prog_req   (prog_req),
        .prom_wr    (prom_wr)
    );

    rom_arbiter #(.ROM_AW(ROM_AW)) rom_arbiter_i (
        .clk_rgb  (clk_rgb),
        .arst_n   (arst_n),
        .prog_req (prog_req),
        .cpu_rd   (cpu_rd),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_valid(cpu_valid),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_mask (mem_mask),
        .mem_rdata(mem_rdata)
    );

    rom_memory #(.ROM_AW(ROM_AW)) rom_memory_i (
        .clk_rgb(clk_rgb),
        .we     (mem_we),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .mask   (mem_mask),
        .rdata  (mem_rdata)
    );

    prom_bank prom_bank_i (
        .clk_rgb(clk_rgb),
        .prom_wr(prom_wr),
        .rd_sel (prom_rd_sel),
        .rd_addr(prom_rd_addr),
        .rd_data(prom_rd_data)
    );

endmodule

`default_nettype wire

// ==== tests/clock_gen.sv ====
/*
 * Testbench clock and reset
 * 10-unit clock, reset held low for the first 3 cycles
 */
`default_nettype none

module clock_gen (
    output logic clk_rgb,
    output logic arst_n
);

    initial begin
        clk_rgb = 1'b0;
        forever #5 clk_rgb = ~clk_rgb; // Period 10
    end

    initial begin
        arst_n <= 1'b0;
        repeat (3) @(posedge clk_rgb);
        arst_n <= 1'b1; // Released on the third edge
    end

endmodule

`default_nettype wire

// ==== tests/rom_load_tb.sv ====
/*
 * ROM loader testbench
 * Table-driven host download, CPU and PROM read-back against a byte model
 */
`default_nettype none

module rom_load_tb import rom_load_pkg::*; ();

    localparam int unsigned PROM_BASE   = 32768;
    localparam int          ROM_AW      = 14;
    localparam int          RD_TIMEOUT  = 200; // Cycles per CPU read
    localparam int          RST_TIMEOUT = 10;

    typedef struct packed {
        ioctl_addr_t addr;
        logic        dl;   // Level of downloading for this byte
        byte_t       data;
    } host_wr_t;

    typedef struct packed {
        logic              is_prom;
        logic              late;  // Memory read done after the burst
        prom_sel_t         sel;
        logic [ROM_AW-1:0] addr;  // Word address or PROM entry
        rom_word_t         exp;
    } rd_entry_t;

    logic              clk_rgb;
    logic              arst_n;
    logic              downloading;
    ioctl_addr_t       ioctl_addr;
    byte_t             ioctl_data;
    logic              ioctl_wr;
    logic              cpu_rd;
    logic [ROM_AW-1:0] cpu_addr;
    rom_word_t         cpu_data;
    logic              cpu_valid;
    prom_sel_t         prom_rd_sel;
    byte_t             prom_rd_addr;
    byte_t             prom_rd_data;

    host_wr_t   load_tab[$];  // Loaded before any read
    host_wr_t   burst_tab[$]; // Program writes racing CPU reads
    rd_entry_t  rd_tab[$];
    rom_word_t  exp_mem [2**ROM_AW];
    byte_t      exp_prom [PROM_COUNT][256];
    logic       prom_known [PROM_COUNT][256];
    integer     seed = 32'h51ca;

    clock_gen clock_gen_i (.clk_rgb(clk_rgb), .arst_n(arst_n));

    rom_load_top #(.PROM_BASE(PROM_BASE), .ROM_AW(ROM_AW)) rom_load_top_i (
        .clk_rgb     (clk_rgb),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .cpu_rd      (cpu_rd),
        .cpu_addr    (cpu_addr),
        .cpu_data    (cpu_data),
        .cpu_valid   (cpu_valid),
        .prom_rd_sel (prom_rd_sel),
        .prom_rd_addr(prom_rd_addr),
        .prom_rd_data(prom_rd_data)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // PROM number of a byte at or above the boundary, -1 when discarded
    function automatic int prom_of(input ioctl_addr_t a);
        if (!a[16])
            return 6 + int'(a[15:13]);
        if (a[12:11] == 2'b01)
            return 5;
        if (a[12]) begin
            case (a[9:8])
                2'd0: return 0;
                2'd1: return 1;
                2'd2: return 2;
                default: return a[5] ? 4 : 3;
            endcase
        end
        return -1;
    endfunction

    // Byte address of entry 0 in each PROM region
    function automatic ioctl_addr_t region_base(input int p);
        case (p)
            0: return 22'h11000;
            1: return 22'h11100;
            2: return 22'h11200;
            3: return 22'h11300;
            4: return 22'h11320; // Bit 5 set selects PROM 4
            5: return 22'h10800;
            default: return ioctl_addr_t'(32'h20000 + (p - 6) * 32'h2000);
        endcase
    endfunction

    // Append a host byte with random data and update the model
    task automatic add_wr(input ioctl_addr_t a, input logic dl, input logic burst);
        host_wr_t          r;
        logic [ROM_AW-1:0] w;
        int                p;
        r = '{addr: a, dl: dl, data: byte_t'($random(seed))};
        if (dl && a < ioctl_addr_t'(PROM_BASE)) begin
            w = ROM_AW'(a >> 1);
            if (a[0])
                exp_mem[w][15:8] = r.data; // Odd byte, high lane
            else
                exp_mem[w][7:0] = r.data;
        end else if (dl) begin
            p = prom_of(a);
            if (p >= 0) begin
                exp_prom[prom_sel_t'(p)][a[7:0]] = r.data;
                prom_known[prom_sel_t'(p)][a[7:0]] = 1'b1;
            end
        end
        if (burst)
            burst_tab.push_back(r);
        else
            load_tab.push_back(r);
    endtask

    task automatic add_rd(input logic is_prom, input logic late, input int sel, input int addr);
        rd_entry_t e;
        e.is_prom = is_prom;
        e.late    = late;
        e.sel     = prom_sel_t'(sel);
        e.addr    = ROM_AW'(addr);
        if (is_prom)
            e.exp = {8'h00, exp_prom[e.sel][byte_t'(addr)]};
        else
            e.exp = exp_mem[e.addr];
        rd_tab.push_back(e);
    endtask

    task automatic build_tables;
        for (int p = 0; p < PROM_COUNT; p++)
            for (int e = 0; e < 256; e++)
                prom_known[prom_sel_t'(p)][byte_t'(e)] = 1'b0;
        for (int b = 0; b < 'h60; b++)
            add_wr(ioctl_addr_t'(b), 1'b1, 1'b0); // Words 0x00..0x2f
        add_wr(22'h007ffe, 1'b1, 1'b0); // Last program word
        add_wr(22'h007fff, 1'b1, 1'b0);
        for (int p = 0; p < PROM_COUNT; p++)
            for (int e = 'h40; e < 'h4e; e++)
                add_wr(region_base(p) | ioctl_addr_t'(e), 1'b1, 1'b0);
        for (int p = 0; p < PROM_COUNT; p++)
            add_wr(region_base(p) | ioctl_addr_t'('h40 + p), 1'b1, 1'b0); // One per PROM
        add_wr(22'h00804a, 1'b1, 1'b0); // First PROM byte past the boundary
        add_wr(22'h000010, 1'b1, 1'b0); // Low lane alone
        add_wr(22'h000013, 1'b1, 1'b0); // High lane alone
        for (int k = 0; k < 8; k++)
            add_wr(ioctl_addr_t'('h10040 + k), 1'b1, 1'b0); // Discarded region
        for (int k = 0; k < 8; k++)
            add_wr(ioctl_addr_t'('h40 + k), 1'b0, 1'b0);    // Not downloading
        for (int p = 0; p < PROM_COUNT; p++)
            add_wr(region_base(p) | 22'h41, 1'b0, 1'b0);
        for (int b = 'h1000; b < 'h1040; b++)
            add_wr(ioctl_addr_t'(b), 1'b1, 1'b1);

        for (int w = 0; w < 'h30; w++)
            add_rd(1'b0, 1'b0, 0, w);
        add_rd(1'b0, 1'b0, 0, 'h3fff);
        for (int w = 'h800; w < 'h820; w++)
            add_rd(1'b0, 1'b1, 0, w);
        for (int p = 0; p < PROM_COUNT; p++)
            for (int e = 'h40; e < 'h70; e++)
                if (prom_known[prom_sel_t'(p)][byte_t'(e)])
                    add_rd(1'b1, 1'b1, p, e);
    endtask

    task automatic drive_row(input host_wr_t r);
        @(posedge clk_rgb);
        downloading <= r.dl;
        ioctl_addr  <= r.addr;
        ioctl_data  <= r.data;
        ioctl_wr    <= 1'b1;
    endtask

    task automatic idle_host;
        @(posedge clk_rgb);
        ioctl_wr <= 1'b0;
    endtask

    task automatic cpu_read(input logic [ROM_AW-1:0] a, input rom_word_t exp);
        int waited;
        @(posedge clk_rgb);
        cpu_rd   <= 1'b1;
        cpu_addr <= a;
        @(posedge clk_rgb);
        cpu_rd   <= 1'b0; // Single-cycle strobe
        waited = 0;
        @(negedge clk_rgb);
        while (!cpu_valid && waited < RD_TIMEOUT) begin
            @(negedge clk_rgb);
            waited++;
        end
        assert (cpu_valid)
            else stop_on_error($sformatf("CPU read of word 0x%04h never returned", a));
        assert (cpu_data == exp)
            else stop_on_error($sformatf("Fail cpu_data word 0x%04h: got 0x%04h, expected 0x%04h",
                                         a, cpu_data, exp));
    endtask

    task automatic prom_read(input prom_sel_t sel, input byte_t entry, input byte_t exp);
        @(posedge clk_rgb);
        prom_rd_sel  <= sel;
        prom_rd_addr <= entry;
        @(posedge clk_rgb); // Registered read
        @(negedge clk_rgb);
        assert (prom_rd_data == exp)
            else stop_on_error($sformatf(
                "Fail prom_rd_data prom 0x%0h entry 0x%02h: got 0x%02h, expected 0x%02h",
                sel, entry, prom_rd_data, exp));
    endtask

    initial begin
        int waited;
        downloading  <= 1'b0;
        ioctl_addr   <= '0;
        ioctl_data   <= '0;
        ioctl_wr     <= 1'b0;
        cpu_rd       <= 1'b0;
        cpu_addr     <= '0;
        prom_rd_sel  <= '0;
        prom_rd_addr <= '0;
        build_tables();
        waited = 0;
        @(negedge clk_rgb);
        while (!arst_n && waited < RST_TIMEOUT) begin
            @(negedge clk_rgb);
            waited++;
        end
        assert (arst_n) else stop_on_error("Reset was never released");
        assert (!cpu_valid)
            else stop_on_error($sformatf("Fail cpu_valid after reset: got 0x%0h, expected 0x0",
                                         cpu_valid));

        foreach (load_tab[i])
            drive_row(load_tab[i]);
        idle_host();
        repeat (3) @(posedge clk_rgb); // Decoder and memory write latency

        fork
            begin
                foreach (burst_tab[i]) begin
                    drive_row(burst_tab[i]);
                    if (i % 4 == 3)
                        idle_host(); // Free cycle for a parked read
                end
                idle_host();
            end
            begin
                foreach (rd_tab[i])
                    if (!rd_tab[i].is_prom && !rd_tab[i].late)
                        cpu_read(rd_tab[i].addr, rd_tab[i].exp);
            end
        join
        repeat (3) @(posedge clk_rgb);

        foreach (rd_tab[i]) begin
            if (rd_tab[i].is_prom)
                prom_read(rd_tab[i].sel, byte_t'(rd_tab[i].addr), byte_t'(rd_tab[i].exp));
            else if (rd_tab[i].late)
                cpu_read(rd_tab[i].addr, rd_tab[i].exp); // Words from the burst
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/rom_load_pkg.sv
logic/download_decoder.sv
logic/rom_arbiter.sv
logic/rom_memory.sv
logic/prom_bank.sv
logic/rom_load_top.sv
tests/clock_gen.sv
tests/rom_load_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the ROM loader testbench; exit status reports the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f verilog.f --top-module rom_load_tb -Mdir obj_dir \
    && ./obj_dir/Vrom_load_tb \
    || { echo "simulation did not complete cleanly"; exit 1; }
